//--- hdl/mdu_config.svh
`ifndef MDU_CONFIG_SVH
`define MDU_CONFIG_SVH

// operand width, one word
`define MDU_XLEN 64

// byte offsets on the wishbone port
`define MDU_ADR_SRC1   8'h00
`define MDU_ADR_SRC2   8'h08
`define MDU_ADR_CMD    8'h10
`define MDU_ADR_STATUS 8'h18
`define MDU_ADR_RESULT 8'h20

// start sample to done pulse
`define MDU_MUL_CYCLES 33
`define MDU_DIV_CYCLES 66

`endif

//--- hdl/mdu_pkg.sv
package mdu_pkg;

	// low nibble of the command word
	typedef enum logic [3:0] {
		OP_MUL    = 4'd0,
		OP_MULH   = 4'd1,
		OP_MULHSU = 4'd2,
		OP_MULHU  = 4'd3,
		OP_MULW   = 4'd4,
		OP_DIV    = 4'd5,
		OP_DIVU   = 4'd6,
		OP_REM    = 4'd7,
		OP_REMU   = 4'd8
	} mdu_op_e;

	// multiplier operand extension, src1 letter first
	typedef enum logic [1:0] {
		SM_SS = 2'b00,
		SM_SU = 2'b01,
		SM_US = 2'b10,
		SM_UU = 2'b11
	} sign_mode_e;

	typedef enum logic [2:0] {
		REG_SRC1   = 3'd0,
		REG_SRC2   = 3'd1,
		REG_CMD    = 3'd2,
		REG_STATUS = 3'd3,
		REG_RESULT = 3'd4,
		REG_NONE   = 3'd7 // unmapped offset
	} reg_idx_e;

endpackage

//--- hdl/booth_mul.sv
`timescale 1ns/10ps
`include "mdu_config.svh"

module booth_mul (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      start,
	input  logic [`MDU_XLEN-1:0]      src1,
	input  logic [`MDU_XLEN-1:0]      src2,
	input  mdu_pkg::sign_mode_e       sign_mode,
	output logic                      done,
	output logic [2*`MDU_XLEN-1:0]    product
);

	localparam int PW = 2*`MDU_XLEN + 2;  // partial product width
	localparam int YW = `MDU_XLEN + 3;    // multiplier, two ext bits, guard bit
	localparam int CW = $clog2(`MDU_MUL_CYCLES);

	logic          x_signed;
	logic          y_signed;
	logic [PW-1:0] x_ext;
	logic [YW-1:0] y_ext;
	logic [PW-1:0] x;
	logic [YW-1:0] yb;
	logic [PW-1:0] p;
	logic          running;
	logic [CW-1:0] cnt;

	// radix-4 recoding of one bit triplet
	function automatic logic [PW-1:0] booth_pp(input logic [PW-1:0] xv, input logic [2:0] sel);
		case (sel)
			3'b001, 3'b010: booth_pp = xv;
			3'b011:         booth_pp = xv << 1;
			3'b100:         booth_pp = -(xv << 1);
			3'b101, 3'b110: booth_pp = -xv;
			default:        booth_pp = '0;
		endcase
	endfunction

	assign x_signed = sign_mode inside {mdu_pkg::SM_SS, mdu_pkg::SM_SU};
	assign y_signed = sign_mode inside {mdu_pkg::SM_SS, mdu_pkg::SM_US};

	always_comb begin
		x_ext = {{(`MDU_XLEN+2){x_signed & src1[`MDU_XLEN-1]}}, src1};
		y_ext = {{2{y_signed & src2[`MDU_XLEN-1]}}, src2, 1'b0}; // bit -1 is zero
	end

	// fixed step count, no early exit on a zero multiplier
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			running <= 1'b0;
			cnt     <= '0;
			done    <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				running <= 1'b1;
				cnt     <= '0;
			end else if (running) begin
				cnt <= cnt + 1'b1;
				if (cnt == CW'(`MDU_MUL_CYCLES - 1)) begin
					running <= 1'b0;
					done    <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			x  <= x_ext;
			yb <= y_ext;
			p  <= '0;
		end else if (running) begin
			p  <= p + booth_pp(x, yb[2:0]);
			x  <= x << 2;
			yb <= yb >> 2; // next triplet overlaps by one bit
		end
	end

	assign product = p[2*`MDU_XLEN-1:0];

	a_no_start_running: assert property (@(posedge clk) disable iff (!rst_n)
		start |-> !running);

	a_done_after_run: assert property (@(posedge clk) disable iff (!rst_n)
		done |-> $past(start, `MDU_MUL_CYCLES + 1));

endmodule

//--- hdl/restoring_div.sv
`timescale 1ns/10ps
`include "mdu_config.svh"

module restoring_div (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 start,
	input  logic [`MDU_XLEN-1:0] dividend,
	input  logic [`MDU_XLEN-1:0] divisor,
	input  logic                 div_signed,
	output logic                 done,
	output logic [`MDU_XLEN-1:0] quotient,
	output logic [`MDU_XLEN-1:0] remainder
);

	localparam int MSB = `MDU_XLEN - 1;
	localparam int CW  = $clog2(`MDU_DIV_CYCLES);

	logic [MSB:0]       dvd_abs;
	logic [MSB:0]       dvs_abs;
	logic [MSB:0]       dvd_q;    // original dividend
	logic [MSB:0]       dvs;
	logic [MSB:0]       quo;
	logic [MSB:0]       rem;
	logic [MSB+1:0]     rem_sh;
	logic [MSB+2:0]     diff;
	logic               neg_q;
	logic               neg_r;
	logic               div_zero;
	logic               ovf;
	logic               running;
	logic [CW-1:0]      cnt;

	assign dvd_abs = (div_signed && dividend[MSB]) ? -dividend : dividend;
	assign dvs_abs = (div_signed && divisor[MSB]) ? -divisor : divisor;

	assign rem_sh = {rem, quo[MSB]};
	assign diff   = {1'b0, rem_sh} - {2'b00, dvs}; // top bit set means restore

	// 64 steps, one sign fix cycle, one cycle to done
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			running <= 1'b0;
			cnt     <= '0;
			done    <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				running <= 1'b1;
				cnt     <= '0;
			end else if (running) begin
				cnt <= cnt + 1'b1;
				if (cnt == CW'(`MDU_DIV_CYCLES - 1)) begin
					running <= 1'b0;
					done    <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			quo      <= dvd_abs;
			rem      <= '0;
			dvs      <= dvs_abs;
			dvd_q    <= dividend;
			neg_q    <= div_signed & (dividend[MSB] ^ divisor[MSB]);
			neg_r    <= div_signed & dividend[MSB];
			div_zero <= (divisor == '0);
			ovf      <= div_signed && (dividend == {1'b1, {MSB{1'b0}}}) && (divisor == '1);
		end else if (running) begin
			if (cnt < CW'(`MDU_XLEN)) begin
				if (!diff[MSB+2]) begin
					rem <= diff[MSB:0];
					quo <= {quo[MSB-1:0], 1'b1};
				end else begin
					rem <= rem_sh[MSB:0];
					quo <= {quo[MSB-1:0], 1'b0};
				end
			end else if (cnt == CW'(`MDU_XLEN)) begin
				if (div_zero) begin
					quotient  <= '1;
					remainder <= dvd_q;
				end else if (ovf) begin
					quotient  <= dvd_q; // most negative / -1
					remainder <= '0;
				end else begin
					quotient  <= neg_q ? -quo : quo;
					remainder <= neg_r ? -rem : rem;
				end
			end
		end
	end

	a_done_after_start: assert property (@(posedge clk) disable iff (!rst_n)
		done |-> $past(start, `MDU_DIV_CYCLES + 1));

endmodule

//--- hdl/mdu_wb_regs.sv
`timescale 1ns/10ps
`include "mdu_config.svh"

module mdu_wb_regs (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   cyc,
	input  logic                   stb,
	input  logic                   we,
	input  logic [7:0]             adr,
	input  logic [`MDU_XLEN-1:0]   dat_w,
	output logic [`MDU_XLEN-1:0]   dat_r,
	output logic                   ack,
	output logic                   mul_start,
	output logic                   div_start,
	output logic [`MDU_XLEN-1:0]   src1,
	output logic [`MDU_XLEN-1:0]   src2,
	output mdu_pkg::sign_mode_e    sign_mode,
	output logic                   div_signed,
	input  logic                   mul_done,
	input  logic                   div_done,
	input  logic [2*`MDU_XLEN-1:0] product,
	input  logic [`MDU_XLEN-1:0]   quotient,
	input  logic [`MDU_XLEN-1:0]   remainder
);

	mdu_pkg::mdu_op_e    op;
	mdu_pkg::mdu_op_e    new_op;
	mdu_pkg::reg_idx_e   idx;
	logic                access;
	logic                wr;
	logic                rd;
	logic                busy;
	logic                done_flag;
	logic                new_is_mul;
	logic [`MDU_XLEN-1:0] result;
	logic [`MDU_XLEN-1:0] rd_data;

	always_comb begin
		case (adr)
			`MDU_ADR_SRC1:   idx = mdu_pkg::REG_SRC1;
			`MDU_ADR_SRC2:   idx = mdu_pkg::REG_SRC2;
			`MDU_ADR_CMD:    idx = mdu_pkg::REG_CMD;
			`MDU_ADR_STATUS: idx = mdu_pkg::REG_STATUS;
			`MDU_ADR_RESULT: idx = mdu_pkg::REG_RESULT;
			default:         idx = mdu_pkg::REG_NONE;
		endcase
	end

	assign access = cyc && stb && !ack; // first sample only
	assign wr     = access && we;
	assign rd     = access && !we;

	assign new_op     = mdu_pkg::mdu_op_e'(dat_w[3:0]);
	assign new_is_mul = new_op inside {mdu_pkg::OP_MUL, mdu_pkg::OP_MULH, mdu_pkg::OP_MULHSU,
		mdu_pkg::OP_MULHU, mdu_pkg::OP_MULW};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ack       <= 1'b0;
			busy      <= 1'b0;
			done_flag <= 1'b0;
			op        <= mdu_pkg::OP_MUL;
			mul_start <= 1'b0;
			div_start <= 1'b0;
		end else begin
			ack       <= access;
			mul_start <= 1'b0;
			div_start <= 1'b0;
			if (mul_done || div_done) begin
				busy      <= 1'b0;
				done_flag <= 1'b1;
			end
			// cmd while busy still gets its ack
			if (wr && idx == mdu_pkg::REG_CMD && !busy) begin
				op        <= new_op;
				busy      <= 1'b1;
				done_flag <= 1'b0;
				mul_start <= new_is_mul;
				div_start <= !new_is_mul;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr && idx == mdu_pkg::REG_SRC1)
			src1 <= dat_w;
		if (wr && idx == mdu_pkg::REG_SRC2)
			src2 <= dat_w;
		if (rd)
			dat_r <= rd_data;
	end

	always_comb begin
		case (op)
			mdu_pkg::OP_MULHSU:  sign_mode = mdu_pkg::SM_SU;
			mdu_pkg::OP_MULHU:   sign_mode = mdu_pkg::SM_UU;
			mdu_pkg::OP_MUL,
			mdu_pkg::OP_MULH,
			mdu_pkg::OP_MULW:    sign_mode = mdu_pkg::SM_SS;
			default:             sign_mode = mdu_pkg::SM_UU; // divider ops
		endcase
	end

	assign div_signed = (op == mdu_pkg::OP_DIV) || (op == mdu_pkg::OP_REM);

	always_comb begin
		case (op)
			mdu_pkg::OP_MUL:    result = product[`MDU_XLEN-1:0];
			mdu_pkg::OP_MULH,
			mdu_pkg::OP_MULHSU,
			mdu_pkg::OP_MULHU:  result = product[2*`MDU_XLEN-1:`MDU_XLEN];
			mdu_pkg::OP_MULW:   result = {{(`MDU_XLEN-32){product[31]}}, product[31:0]};
			mdu_pkg::OP_REM,
			mdu_pkg::OP_REMU:   result = remainder;
			default:            result = quotient;
		endcase
	end

	always_comb begin
		case (idx)
			mdu_pkg::REG_SRC1:   rd_data = src1;
			mdu_pkg::REG_SRC2:   rd_data = src2;
			mdu_pkg::REG_CMD:    rd_data = {{(`MDU_XLEN-4){1'b0}}, op};
			mdu_pkg::REG_STATUS: rd_data = {{(`MDU_XLEN-2){1'b0}}, done_flag, busy};
			mdu_pkg::REG_RESULT: rd_data = result;
			default:             rd_data = '0;
		endcase
	end

	// master holds cyc and stb until it sees ack
	a_ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		ack |-> cyc && stb);

	// an engine only finishes a command that was started
	a_done_when_busy: assert property (@(posedge clk) disable iff (!rst_n)
		(mul_done || div_done) |-> busy);

endmodule

//--- hdl/mdu_top.sv
`timescale 1ns/10ps
`include "mdu_config.svh"

module mdu_top (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 cyc,
	input  logic                 stb,
	input  logic                 we,
	input  logic [7:0]           adr,
	input  logic [`MDU_XLEN-1:0] dat_w,
	output logic [`MDU_XLEN-1:0] dat_r,
	output logic                 ack
);

	logic                   mul_start;
	logic                   div_start;
	logic [`MDU_XLEN-1:0]   src1;
	logic [`MDU_XLEN-1:0]   src2;
	mdu_pkg::sign_mode_e    sign_mode;
	logic                   div_signed;
	logic                   mul_done;
	logic                   div_done;
	logic [2*`MDU_XLEN-1:0] product;
	logic [`MDU_XLEN-1:0]   quotient;
	logic [`MDU_XLEN-1:0]   remainder;

	mdu_wb_regs i_regs (
		.clk        (clk),
		.rst_n      (rst_n),
		.cyc        (cyc),
		.stb        (stb),
		.we         (we),
		.adr        (adr),
		.dat_w      (dat_w),
		.dat_r      (dat_r),
		.ack        (ack),
		.mul_start  (mul_start),
		.div_start  (div_start),
		.src1       (src1),
		.src2       (src2),
		.sign_mode  (sign_mode),
		.div_signed (div_signed),
		.mul_done   (mul_done),
		.div_done   (div_done),
		.product    (product),
		.quotient   (quotient),
		.remainder  (remainder)
	);

	booth_mul i_mul (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (mul_start),
		.src1      (src1),
		.src2      (src2),
		.sign_mode (sign_mode),
		.done      (mul_done),
		.product   (product)
	);

	restoring_div i_div (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (div_start),
		.dividend   (src1),
		.divisor    (src2),
		.div_signed (div_signed),
		.done       (div_done),
		.quotient   (quotient),
		.remainder  (remainder)
	);

endmodule

//--- verification/mdu_tb.sv
`timescale 1ns/10ps
`include "mdu_config.svh"

module mdu_tb;

	localparam int NUM_DIR  = 31;
	localparam int NUM_RAND = 16;
	localparam int NUM_ALL  = NUM_DIR + NUM_RAND + 2; // plus reset and busy tests
	localparam int LIMIT    = NUM_ALL * (`MDU_DIV_CYCLES + 40) + 200;
	localparam logic [63:0] MIN_NEG = 64'h8000_0000_0000_0000;
	localparam logic [63:0] ONES    = 64'hffff_ffff_ffff_ffff;

	logic        clk;
	logic        rst_n;
	logic        cyc;
	logic        stb;
	logic        we;
	logic [7:0]  adr;
	logic [63:0] dat_w;
	logic [63:0] dat_r;
	logic        ack;

	mdu_pkg::mdu_op_e vec_op [NUM_DIR];
	logic [63:0]      vec_a [NUM_DIR];
	logic [63:0]      vec_b [NUM_DIR];
	logic [63:0]      vec_exp [NUM_DIR];
	int               vec_cnt;
	int               cycles;
	int               last_ack;
	int               errors;
	int               passes;
	int               fails;
	logic [31:0]      lfsr;

	mdu_top i_dut (
		.clk   (clk),
		.rst_n (rst_n),
		.cyc   (cyc),
		.stb   (stb),
		.we    (we),
		.adr   (adr),
		.dat_w (dat_w),
		.dat_r (dat_r),
		.ack   (ack)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= LIMIT) begin
			$display("timeout: run still going after %0d clock cycles", cycles);
			$display("=== FAIL ===");
			$finish;
		end
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_word(output logic [63:0] w);
		w = '0;
		for (int i = 0; i < 64; i++) begin
			lfsr = lfsr_next(lfsr);
			w    = {w[62:0], lfsr[0]}; // one step per bit
		end
	endtask

	// RV64M result rules, 128-bit products
	function automatic logic [63:0] model_result(input mdu_pkg::mdu_op_e op,
		input logic [63:0] a, input logic [63:0] b);
		logic [127:0] ea;
		logic [127:0] eb;
		logic [127:0] prod;
		logic [63:0]  ma;
		logic [63:0]  mb;
		logic [63:0]  q;
		logic [63:0]  r;
		logic         a_s;
		logic         b_s;
		logic         sgn;
		a_s  = (op != mdu_pkg::OP_MULHU);
		b_s  = (op != mdu_pkg::OP_MULHU) && (op != mdu_pkg::OP_MULHSU);
		ea   = {{64{a_s & a[63]}}, a};
		eb   = {{64{b_s & b[63]}}, b};
		prod = ea * eb;
		sgn  = (op == mdu_pkg::OP_DIV) || (op == mdu_pkg::OP_REM);
		ma   = (sgn && a[63]) ? -a : a;
		mb   = (sgn && b[63]) ? -b : b;
		if (b == 64'd0) begin
			q = ONES;
			r = a;
		end else if (sgn && a == MIN_NEG && b == ONES) begin
			q = a;
			r = 64'd0;
		end else begin
			q = ma / mb;
			r = ma % mb;
			if (sgn && (a[63] ^ b[63]))
				q = -q;
			if (sgn && a[63])
				r = -r; // remainder follows dividend
		end
		case (op)
			mdu_pkg::OP_MUL:    return prod[63:0];
			mdu_pkg::OP_MULH,
			mdu_pkg::OP_MULHSU,
			mdu_pkg::OP_MULHU:  return prod[127:64];
			mdu_pkg::OP_MULW:   return {{32{prod[31]}}, prod[31:0]};
			mdu_pkg::OP_DIV,
			mdu_pkg::OP_DIVU:   return q;
			default:            return r;
		endcase
	endfunction

	function automatic int latency_of(input mdu_pkg::mdu_op_e op);
		return (op <= mdu_pkg::OP_MULW) ? `MDU_MUL_CYCLES : `MDU_DIV_CYCLES;
	endfunction

	task automatic add_vec(input mdu_pkg::mdu_op_e op, input logic [63:0] a,
		input logic [63:0] b, input logic [63:0] e);
		vec_op[vec_cnt]  = op;
		vec_a[vec_cnt]   = a;
		vec_b[vec_cnt]   = b;
		vec_exp[vec_cnt] = e;
		vec_cnt++;
	endtask

	task automatic load_table();
		add_vec(mdu_pkg::OP_MUL, 64'd3, 64'd5, 64'd15);
		add_vec(mdu_pkg::OP_MUL, ONES, ONES, 64'd1);
		add_vec(mdu_pkg::OP_MUL, 64'h1_0000_0000, 64'h1_0000_0000, 64'd0);
		add_vec(mdu_pkg::OP_MULW, 64'h7fff_ffff, 64'd2, 64'hffff_ffff_ffff_fffe);
		add_vec(mdu_pkg::OP_MULW, 64'hffff_0000_0000_0003, 64'd5, 64'd15);
		add_vec(mdu_pkg::OP_MULW, 64'h1234, 64'h10, 64'h12340);
		add_vec(mdu_pkg::OP_MULH, ONES, ONES, 64'd0);
		add_vec(mdu_pkg::OP_MULH, MIN_NEG, MIN_NEG, 64'h4000_0000_0000_0000);
		add_vec(mdu_pkg::OP_MULH, MIN_NEG, ONES, 64'd0);
		add_vec(mdu_pkg::OP_MULH, ONES, 64'd2, ONES);
		add_vec(mdu_pkg::OP_MULHU, ONES, ONES, 64'hffff_ffff_ffff_fffe);
		add_vec(mdu_pkg::OP_MULHU, MIN_NEG, 64'd2, 64'd1);
		add_vec(mdu_pkg::OP_MULHSU, ONES, ONES, ONES);
		add_vec(mdu_pkg::OP_MULHSU, 64'd2, ONES, 64'd1);
		add_vec(mdu_pkg::OP_MULHSU, MIN_NEG, 64'd2, ONES);
		add_vec(mdu_pkg::OP_DIV, 64'd20, 64'd3, 64'd6);
		add_vec(mdu_pkg::OP_DIV, 64'hffff_ffff_ffff_ffec, 64'd3, 64'hffff_ffff_ffff_fffa);
		add_vec(mdu_pkg::OP_DIV, 64'd20, 64'hffff_ffff_ffff_fffd, 64'hffff_ffff_ffff_fffa);
		add_vec(mdu_pkg::OP_DIV, 64'hffff_ffff_ffff_ffec, 64'hffff_ffff_ffff_fffd, 64'd6);
		add_vec(mdu_pkg::OP_REM, 64'hffff_ffff_ffff_ffec, 64'd3, 64'hffff_ffff_ffff_fffe);
		add_vec(mdu_pkg::OP_REM, 64'd20, 64'hffff_ffff_ffff_fffd, 64'd2);
		add_vec(mdu_pkg::OP_DIVU, ONES, 64'd2, 64'h7fff_ffff_ffff_ffff);
		add_vec(mdu_pkg::OP_REMU, ONES, 64'd2, 64'd1);
		add_vec(mdu_pkg::OP_DIV, 64'd42, 64'd0, ONES);
		add_vec(mdu_pkg::OP_REM, 64'd42, 64'd0, 64'd42);
		add_vec(mdu_pkg::OP_DIVU, 64'd7, 64'd0, ONES);
		add_vec(mdu_pkg::OP_REMU, 64'd7, 64'd0, 64'd7);
		add_vec(mdu_pkg::OP_DIV, MIN_NEG, ONES, MIN_NEG);
		add_vec(mdu_pkg::OP_REM, MIN_NEG, ONES, 64'd0);
		add_vec(mdu_pkg::OP_DIVU, MIN_NEG, ONES, 64'd0);
		add_vec(mdu_pkg::OP_REMU, MIN_NEG, ONES, MIN_NEG);
	endtask

	// entered on a falling edge with the request driven
	task automatic finish_access(output logic [63:0] d);
		@(negedge clk);
		while (!ack)
			@(negedge clk);
		d        = dat_r;
		last_ack = cycles;
		@(negedge clk); // request held over the edge that takes the ack
		cyc      = 1'b0;
		stb      = 1'b0;
		we       = 1'b0;
		if (ack) begin
			$display("ack stayed high for a second cycle at %0t ns", $time);
			errors++;
		end
	endtask

	task automatic wb_write(input logic [7:0] a, input logic [63:0] d);
		logic [63:0] ignored;
		cyc   = 1'b1;
		stb   = 1'b1;
		we    = 1'b1;
		adr   = a;
		dat_w = d;
		finish_access(ignored);
	endtask

	task automatic wb_read(input logic [7:0] a, output logic [63:0] d);
		cyc = 1'b1;
		stb = 1'b1;
		we  = 1'b0;
		adr = a;
		finish_access(d);
	endtask

	task automatic start_op(input mdu_pkg::mdu_op_e op, input logic [63:0] a,
		input logic [63:0] b, output int cmd_ack);
		wb_write(`MDU_ADR_SRC1, a);
		wb_write(`MDU_ADR_SRC2, b);
		wb_write(`MDU_ADR_CMD, {60'd0, op});
		cmd_ack = last_ack;
	endtask

	task automatic collect(input int lat, input int cmd_ack, output logic [63:0] res);
		logic [63:0] status;
		do
			wb_read(`MDU_ADR_STATUS, status);
		while (!status[1]);
		if (last_ack - cmd_ack < lat + 1) begin
			$display("done was reported %0d cycles after the command, too early for the engine",
				last_ack - cmd_ack);
			errors++;
		end
		wb_read(`MDU_ADR_RESULT, res);
	endtask

	task automatic report(input int num, input string label, input logic [63:0] got,
		input logic [63:0] exp, input int err_before);
		if (got !== exp) begin
			$display("mismatch at %0t ns: test %0d %s got %h expected %h",
				$time, num, label, got, exp);
			errors++;
		end
		if (errors == err_before) begin
			passes++;
			$display("test %0d %s: ok", num, label);
		end else begin
			fails++;
			$display("test %0d %s: failed", num, label);
		end
	endtask

	task automatic run_vec(input int num, input mdu_pkg::mdu_op_e op, input logic [63:0] a,
		input logic [63:0] b, input logic [63:0] exp);
		int          err_before;
		int          cmd_ack;
		logic [63:0] got;
		err_before = errors;
		start_op(op, a, b, cmd_ack);
		collect(latency_of(op), cmd_ack, got);
		report(num, op.name(), got, exp, err_before);
	endtask

	initial begin
		int               err_before;
		int               cmd_ack;
		int               num;
		mdu_pkg::mdu_op_e op;
		logic [63:0]      a;
		logic [63:0]      b;
		logic [63:0]      rd;
		rst_n    = 1'b0;
		cyc      = 1'b0;
		stb      = 1'b0;
		we       = 1'b0;
		adr      = 8'h00;
		dat_w    = 64'd0;
		cycles   = 0;
		last_ack = 0;
		errors   = 0;
		passes   = 0;
		fails    = 0;
		vec_cnt  = 0;
		lfsr     = 32'h26e6_440b;
		load_table();
		repeat (10) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);

		err_before = errors;
		wb_read(`MDU_ADR_STATUS, rd);
		report(0, "reset status", rd, 64'd0, err_before);

		for (int i = 0; i < vec_cnt; i++)
			run_vec(i + 1, vec_op[i], vec_a[i], vec_b[i], vec_exp[i]);
		num = vec_cnt + 1;

		// second command lands while the multiplier runs
		err_before = errors;
		start_op(mdu_pkg::OP_MUL, 64'd7, 64'd6, cmd_ack);
		wb_write(`MDU_ADR_CMD, {60'd0, mdu_pkg::OP_DIV});
		wb_read(`MDU_ADR_CMD, rd);
		if (rd[3:0] !== mdu_pkg::OP_MUL) begin
			$display("mismatch at %0t ns: command register shows op %0d", $time, rd[3:0]);
			errors++;
		end
		wb_read(`MDU_ADR_SRC1, rd);
		if (rd !== 64'd7) begin
			$display("mismatch at %0t ns: src1 reads back %h", $time, rd);
			errors++;
		end
		wb_read(`MDU_ADR_SRC2, rd);
		if (rd !== 64'd6) begin
			$display("mismatch at %0t ns: src2 reads back %h", $time, rd);
			errors++;
		end
		collect(`MDU_MUL_CYCLES, cmd_ack, rd);
		report(num, "cmd while busy", rd, 64'd42, err_before);
		num++;

		for (int i = 0; i < NUM_RAND; i++) begin
			op = mdu_pkg::mdu_op_e'(4'(i % 9));
			rand_word(a);
			rand_word(b);
			if (op >= mdu_pkg::OP_DIV)
				b = b >> b[5:0]; // spread divisor sizes
			run_vec(num, op, a, b, model_result(op, a, b));
			num++;
		end

		$display("tests passed %0d failed %0d", passes, fails);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

//--- build.f
+incdir+hdl
hdl/mdu_pkg.sv
hdl/booth_mul.sv
hdl/restoring_div.sv
hdl/mdu_wb_regs.sv
hdl/mdu_top.sv
verification/mdu_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/10ps --top-module mdu_tb -f build.f -o mdu_sim
	./obj_dir/mdu_sim > sim.log 2>&1 || true
	cat sim.log
	! grep -q "=== FAIL ===" sim.log
	grep -q "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log
